/* src/fifo_pkg.sv */
// Shared FIFO types; pointers wider than MAX_PTR_W bits and payloads other than 16 bits are not supported.
package fifo_pkg;

  localparam int ITEM_DATA_W = 16;
  localparam int MAX_PTR_W = 8;
  localparam int LEVEL_W = MAX_PTR_W + 1; // enough for 2**MAX_PTR_W items plus the output register.

  // one stored and transferred item, 17 bits.
  typedef struct packed {
    logic [ITEM_DATA_W-1:0] data;
    logic                   last;
  } fifo_item_t;

  typedef struct packed {
    logic                 push;  // item accepted at this edge.
    logic [MAX_PTR_W-1:0] w_ptr; // zero-extended write pointer.
  } write_report_t;

  typedef struct packed {
    logic                 pop;     // consumer took the output item.
    logic                 fetch;   // memory read issued toward the output register.
    logic                 holding; // output register occupied.
    logic [MAX_PTR_W-1:0] r_ptr;
  } read_report_t;

  // the encoding is {fetch, push}, so memory traffic maps straight onto it.
  typedef enum logic [1:0] {
    OP_NONE,
    OP_WRITE,
    OP_READ,
    OP_BOTH
  } fifo_op_t;

  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_PARTIAL,
    ST_FULL,
    ST_LAST // exactly one item left in memory.
  } occ_state_t;

endpackage

/* src/fifo_write_ctrl.sv */
// Input side of the FIFO; accepts whenever the memory is not full and never compares pointers itself.
module fifo_write_ctrl
  import fifo_pkg::*;
#(
  parameter int PTR_WIDTH = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  fifo_item_t           in_item,
  input  logic                 mem_full,
  output logic                 wr_en,
  output logic [PTR_WIDTH-1:0] wr_addr,
  output fifo_item_t           wr_item,
  output write_report_t        wr_rep
);

  logic [PTR_WIDTH-1:0] w_ptr;
  logic                 push;

  assign in_ready = ~mem_full; // mem_full comes from a register, so this is glitch free.
  assign push = in_valid & in_ready;

  // the item goes into memory at the same edge that accepts it.
  assign wr_en = push;
  assign wr_addr = w_ptr;
  assign wr_item = in_item;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_ptr <= '0;
    end else if (push) begin
      w_ptr <= w_ptr + 1'b1; // wraps at the memory depth.
    end
  end

  assign wr_rep = '{push: push, w_ptr: MAX_PTR_W'(w_ptr)};

  // The item is written straight from the port at the accepting edge.
  // A producer that changes its offer before it is taken would lose that item.
  a_in_hold: assert property (
    @(posedge clk) disable iff (rst)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_item))
  ) else $error("producer changed its offer under back-pressure");

endmodule

/* src/fifo_read_ctrl.sv */
// Output side of the FIFO with one show-ahead register; fetches take two edges, so a steady stream
// leaves at most one item every two cycles.
module fifo_read_ctrl
  import fifo_pkg::*;
#(
  parameter int PTR_WIDTH = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 out_valid,
  output fifo_item_t           out_item,
  input  logic                 out_ready,
  input  logic                 mem_has_item,
  output logic                 rd_en,
  output logic [PTR_WIDTH-1:0] rd_addr,
  input  fifo_item_t           rd_item,
  output read_report_t         rd_rep
);

  logic [PTR_WIDTH-1:0] r_ptr;
  logic                 pending; // memory read data arrives this cycle.
  logic                 pop;
  logic                 fetch;

  assign pop = out_valid & out_ready;

  // The output register must be free when the fetched item lands one edge later.
  // While a fetch is pending the register is empty, so a second fetch is held off.
  assign fetch = mem_has_item & ~pending & (~out_valid | out_ready);

  assign rd_en = fetch;
  assign rd_addr = r_ptr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      r_ptr <= '0;
      pending <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      pending <= fetch;
      if (fetch) begin
        r_ptr <= r_ptr + 1'b1;
      end
      if (pending) begin
        out_valid <= 1'b1;
      end else if (pop) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pending) begin
      out_item <= rd_item; // only loads into an empty register.
    end
  end

  assign rd_rep = '{
    pop: pop,
    fetch: fetch,
    holding: out_valid,
    r_ptr: MAX_PTR_W'(r_ptr)
  };

  // a stalled consumer must see the same item on the next cycle.
  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_item))
  ) else $error("output item changed under back-pressure");

  a_load_into_empty: assert property (
    @(posedge clk) disable iff (rst)
    pending |-> !out_valid
  ) else $error("fetched item landed on an occupied output register");

endmodule

/* src/fifo_mem.sv */
// Simple dual-port storage; a read and a write to one address at the same edge is not handled.
module fifo_mem
  import fifo_pkg::*;
#(
  parameter int PTR_WIDTH = 3
) (
  input  logic                 clk,
  input  logic                 wr_en,
  input  logic [PTR_WIDTH-1:0] wr_addr,
  input  fifo_item_t           wr_item,
  input  logic                 rd_en,
  input  logic [PTR_WIDTH-1:0] rd_addr,
  output fifo_item_t           rd_item
);

  localparam int DEPTH = 2 ** PTR_WIDTH;

  fifo_item_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_item;
    end
  end

  // Registered read port.
  // rd_item keeps its value between reads, which the output register relies on.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_item <= mem[rd_addr];
    end
  end

endmodule

/* src/fifo_occupancy.sv */
// Occupancy tracking for the FIFO; flags are registered and valid one cycle after the traffic.
module fifo_occupancy
  import fifo_pkg::*;
#(
  parameter int PTR_WIDTH = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  write_report_t      wr_rep,
  input  read_report_t       rd_rep,
  output logic               mem_full,
  output logic               mem_has_item,
  output logic [LEVEL_W-1:0] level
);

  localparam int DEPTH = 2 ** PTR_WIDTH;
  localparam int CNT_W = PTR_WIDTH + 1;

  fifo_op_t         op;
  occ_state_t       state;
  occ_state_t       state_next;
  logic [CNT_W-1:0] mem_count;
  logic [CNT_W-1:0] count_next;
  logic             fetch_d; // an item is on its way to the output register.

  assign op = fifo_op_t'({rd_rep.fetch, wr_rep.push});

  always_comb begin
    case (op)
      OP_WRITE: count_next = mem_count + 1'b1;
      OP_READ:  count_next = mem_count - 1'b1;
      default:  count_next = mem_count; // none, or a write and a fetch together.
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_EMPTY: begin
        if (op == OP_WRITE) state_next = ST_LAST;
      end
      ST_LAST: begin
        if (op == OP_WRITE) state_next = ST_PARTIAL;
        else if (op == OP_READ) state_next = ST_EMPTY;
      end
      ST_PARTIAL: begin
        if (op == OP_WRITE && mem_count == CNT_W'(DEPTH - 1)) begin
          state_next = ST_FULL;
        end else if (op == OP_READ && mem_count == CNT_W'(2)) begin
          state_next = ST_LAST;
        end
      end
      ST_FULL: begin
        if (op == OP_READ) state_next = ST_PARTIAL;
      end
      default: state_next = ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_EMPTY;
      mem_count <= '0;
      fetch_d <= 1'b0;
      level <= '0;
      mem_full <= 1'b1; // keeps in_ready low until the first edge after reset.
      mem_has_item <= 1'b0;
    end else begin
      state <= state_next;
      mem_count <= count_next;
      fetch_d <= rd_rep.fetch;
      level <= level + LEVEL_W'(wr_rep.push) - LEVEL_W'(rd_rep.pop);
      mem_full <= (state_next == ST_FULL);
      mem_has_item <= (state_next != ST_EMPTY);
    end
  end

  // The two pointers live in separate controllers.
  // Their distance must match the count kept here.
  a_ptr_distance: assert property (
    @(posedge clk) disable iff (rst)
    (wr_rep.w_ptr[PTR_WIDTH-1:0] - rd_rep.r_ptr[PTR_WIDTH-1:0]) == mem_count[PTR_WIDTH-1:0]
  ) else $error("pointer distance differs from memory count");

  a_no_write_full: assert property (
    @(posedge clk) disable iff (rst)
    (state == ST_FULL) |-> !(op inside {OP_WRITE, OP_BOTH})
  ) else $error("write in full state");

  a_no_read_empty: assert property (
    @(posedge clk) disable iff (rst)
    (state == ST_EMPTY) |-> !(op inside {OP_READ, OP_BOTH})
  ) else $error("read in empty state");

  // every item counted in level sits in memory, in flight, or in the output register.
  a_level_split: assert property (
    @(posedge clk) disable iff (rst)
    level == LEVEL_W'(mem_count) + LEVEL_W'(fetch_d) + LEVEL_W'(rd_rep.holding)
  ) else $error("level does not match memory and output contents");

endmodule

/* src/fifo_top.sv */
// Top level of the FIFO; holds 2**PTR_WIDTH items plus one, PTR_WIDTH from 2 to 8, no fixed latency.
module fifo_top
  import fifo_pkg::*;
#(
  parameter int PTR_WIDTH = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  fifo_item_t         in_item,
  output logic               out_valid,
  input  logic               out_ready,
  output fifo_item_t         out_item,
  output logic [LEVEL_W-1:0] level
);

  write_report_t        wr_rep;
  read_report_t         rd_rep;
  logic                 mem_full;
  logic                 mem_has_item;
  logic                 wr_en;
  logic [PTR_WIDTH-1:0] wr_addr;
  fifo_item_t           wr_item;
  logic                 rd_en;
  logic [PTR_WIDTH-1:0] rd_addr;
  fifo_item_t           rd_item;

  if (PTR_WIDTH < 2 || PTR_WIDTH > MAX_PTR_W) begin : g_bad_width
    $error("PTR_WIDTH must be between 2 and MAX_PTR_W");
  end

  fifo_write_ctrl #(.PTR_WIDTH(PTR_WIDTH)) u_write_ctrl (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_item  (in_item),
    .mem_full (mem_full),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_item  (wr_item),
    .wr_rep   (wr_rep)
  );

  fifo_read_ctrl #(.PTR_WIDTH(PTR_WIDTH)) u_read_ctrl (
    .clk          (clk),
    .rst          (rst),
    .out_valid    (out_valid),
    .out_item     (out_item),
    .out_ready    (out_ready),
    .mem_has_item (mem_has_item),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_item      (rd_item),
    .rd_rep       (rd_rep)
  );

  fifo_mem #(.PTR_WIDTH(PTR_WIDTH)) u_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_item (wr_item),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_item (rd_item)
  );

  // both controllers get their flags from here and nowhere else.
  fifo_occupancy #(.PTR_WIDTH(PTR_WIDTH)) u_occupancy (
    .clk          (clk),
    .rst          (rst),
    .wr_rep       (wr_rep),
    .rd_rep       (rd_rep),
    .mem_full     (mem_full),
    .mem_has_item (mem_has_item),
    .level        (level)
  );

endmodule

/* bench/fifo_tb.sv */
// Random regression for fifo_top at PTR_WIDTH 3; inputs change 1 time unit after each rising edge.
module fifo_tb
  import fifo_pkg::*;
();

  localparam int PTR_WIDTH = 3;
  localparam int DEPTH = 2 ** PTR_WIDTH;
  localparam int NUM_ITEMS = 3000;
  localparam int RESET_CYCLES = 5;
  localparam int RUN_TIMEOUT = 100000;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int IDLE_CYCLES = 20;

  logic               clk = 1'b0;
  logic               rst;
  logic               in_valid;
  logic               in_ready;
  fifo_item_t         in_item;
  logic               out_valid;
  logic               out_ready;
  fifo_item_t         out_item;
  logic [LEVEL_W-1:0] level;

  fifo_item_t  model[$]; // items accepted but not yet delivered.
  logic        in_fire;
  logic        out_fire;
  logic        stalled;
  fifo_item_t  in_cap;
  fifo_item_t  out_cap;
  int          accepted;
  int          phase;
  int          phase_left;
  int          cycles;

  fifo_top #(.PTR_WIDTH(PTR_WIDTH)) uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_item   (in_item),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_item  (out_item),
    .level     (level)
  );

  always #5 clk = ~clk;

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic fail_plain(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic check_item(input string name, input fifo_item_t exp, input fifo_item_t got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic [LEVEL_W-1:0] exp,
                             input logic [LEVEL_W-1:0] got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      stop_run();
    end
  endtask

  function automatic logic chance(input int percent);
    return int'($urandom % 100) < percent;
  endfunction

  task automatic check_reset_outputs();
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("in_ready", 1'b0, in_ready);
    check_level("level", '0, level);
  endtask

  // phases are free flow (0), stalled consumer (1) and idle producer (2).
  task automatic pick_phase();
    phase = int'($urandom % 3);
    phase_left = 20 + int'($urandom % 60);
  endtask

  task automatic drive_random();
    int in_pct;
    int out_pct;
    if (phase_left == 0) begin
      pick_phase();
    end
    phase_left = phase_left - 1;
    in_pct = (phase == 2) ? 10 : 85;
    out_pct = (phase == 1) ? 0 : 90; // a stalled consumer holds out_ready low for the whole phase.
    // an offered item stays on the port until it is taken.
    if (!in_valid || in_fire) begin
      if (accepted < NUM_ITEMS && chance(in_pct)) begin
        in_valid = 1'b1;
        in_item.data = ITEM_DATA_W'($urandom);
        in_item.last = chance(12);
      end else begin
        in_valid = 1'b0;
      end
    end
    out_ready = chance(out_pct);
  endtask

  // DUT outputs only change at edges, so the handshakes are known once inputs are driven.
  task automatic capture_handshakes();
    in_fire = in_valid & in_ready;
    out_fire = out_valid & out_ready;
    stalled = out_valid & ~out_ready;
    in_cap = in_item;
    out_cap = out_item;
  endtask

  task automatic advance_and_check();
    fifo_item_t head;
    @(posedge clk);
    #1;
    if (in_fire) begin
      model.push_back(in_cap);
      accepted++;
    end
    if (out_fire) begin
      if (model.size() == 0) begin
        fail_plain("output handshake while the model queue is empty");
      end else begin
        head = model.pop_front();
        check_item("out_item", head, out_cap);
      end
    end
    if (stalled) begin
      check_flag("out_valid", 1'b1, out_valid);
      check_item("out_item", out_cap, out_item); // held item must not move.
    end
    if (model.size() > DEPTH + 1) begin
      fail_plain("model holds more items than the FIFO can store");
    end
    check_level("level", LEVEL_W'(model.size()), level);
    if (model.size() < DEPTH) begin
      check_flag("in_ready", 1'b1, in_ready);
    end
    if (model.size() == 0) begin
      check_flag("out_valid", 1'b0, out_valid);
    end
  endtask

  task automatic drain_and_finish();
    cycles = 0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    while ((model.size() != 0 || out_valid) && cycles < DRAIN_TIMEOUT) begin
      capture_handshakes();
      advance_and_check();
      cycles++;
    end
    if (model.size() != 0 || out_valid) begin
      fail_plain("FIFO did not drain within 2000 cycles");
    end else begin
      repeat (IDLE_CYCLES) begin
        capture_handshakes();
        advance_and_check();
        check_flag("out_valid", 1'b0, out_valid);
        check_level("level", '0, level);
      end
      $display("Regression passed");
      $finish;
    end
  endtask

  initial begin
    void'($urandom(33));
    rst = 1'b1;
    in_valid = 1'b0;
    in_item = '0;
    out_ready = 1'b0;
    in_fire = 1'b0;
    out_fire = 1'b0;
    stalled = 1'b0;
    in_cap = '0;
    out_cap = '0;
    accepted = 0;
    phase = 0;
    phase_left = 0;
    cycles = 0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_reset_outputs();
    end
    rst = 1'b0;
    check_reset_outputs(); // flags stay low up to the first edge after release.
    while (accepted < NUM_ITEMS && cycles < RUN_TIMEOUT) begin
      drive_random();
      capture_handshakes();
      advance_and_check();
      cycles++;
    end
    if (accepted < NUM_ITEMS) begin
      fail_plain("timed out before all items were accepted");
    end else begin
      drain_and_finish();
    end
  end

endmodule

/* vlog.f */
src/fifo_pkg.sv
src/fifo_write_ctrl.sv
src/fifo_read_ctrl.sv
src/fifo_mem.sv
src/fifo_occupancy.sv
src/fifo_top.sv
bench/fifo_tb.sv

/* run.sh */
#!/bin/sh
# Builds the FIFO regression with Verilator and runs it; the exit status is the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  -f vlog.f \
  --top-module fifo_tb \
  --Mdir obj_dir \
  -o fifo_sim
./obj_dir/fifo_sim
